//--- dmem.f
+incdir+hdl
hdl/dmem_pkg.sv
hdl/store_align.sv
hdl/ram_1rw.sv
hdl/load_extend.sv
hdl/dmem_top.sv
testbench/dmem_properties.sv
testbench/tb_dmem_top.sv

//--- hdl/dmem_defines.svh
`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

// memory geometry for the core's data memory

// number of 32-bit words in the RAM
`define DMEM_DEPTH 256

// data path width, one word
`define DMEM_DWIDTH 32

// byte address width, covers DMEM_DEPTH words of 4 bytes
`define DMEM_AWIDTH 10

// the two low address bits select the byte lane,
// the rest pick the word
// a halfword must sit at offset 0 or 2
// and a word at offset 0

`endif

//--- hdl/dmem_pkg.sv
`default_nettype none
`include "dmem_defines.svh"

package dmem_pkg;

    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_e;

    typedef struct packed {
        mem_op_e                  op;
        logic [`DMEM_AWIDTH-1:0]  addr;     // byte address
        logic [`DMEM_DWIDTH-1:0]  data;     // store data, low bits used for sb/sh
    } mem_req_t;

    typedef struct packed {
        logic                     cs_n;
        logic                     we_n;
        logic [`DMEM_DWIDTH/8-1:0] wmask;
        logic [`DMEM_AWIDTH-3:0]  addr;     // word address
        logic [`DMEM_DWIDTH-1:0]  wdata;
    } ram_cmd_t;

    // what the load side needs to know one cycle after the request
    typedef struct packed {
        logic       valid;
        mem_op_e    op;
        logic [1:0] off;
        logic       fault;
    } load_ctx_t;

    typedef struct packed {
        logic                    valid;
        logic                    fault;
        logic [`DMEM_DWIDTH-1:0] data;
    } load_rsp_t;

endpackage

`default_nettype wire

//--- hdl/dmem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmem_defines.svh"

module dmem_top
    import dmem_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_req,
    input  wire mem_req_t   i_req_bits,
    output load_rsp_t       o_rsp
);

    ram_cmd_t                ram_cmd;
    load_ctx_t               load_ctx;
    logic [`DMEM_DWIDTH-1:0] ram_rdata;

    store_align u_store_align (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (i_req),
        .i_req_bits (i_req_bits),
        .o_ram_cmd  (ram_cmd),
        .o_load_ctx (load_ctx)
    );

    ram_1rw #(
        .DEPTH  (`DMEM_DEPTH),
        .DWIDTH (`DMEM_DWIDTH)
    ) u_ram (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cs_n  (ram_cmd.cs_n),
        .i_we_n  (ram_cmd.we_n),
        .i_wmask (ram_cmd.wmask),
        .i_addr  (ram_cmd.addr),
        .i_wdata (ram_cmd.wdata),
        .o_rdata (ram_rdata)
    );

    load_extend u_load_extend (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_load_ctx (load_ctx),
        .i_rdata    (ram_rdata),
        .o_rsp      (o_rsp)
    );

endmodule

`default_nettype wire

//--- hdl/load_extend.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmem_defines.svh"

module load_extend
    import dmem_pkg::*;
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire        load_ctx_t   i_load_ctx,
    input  wire [`DMEM_DWIDTH-1:0]  i_rdata,
    output load_rsp_t               o_rsp
);

    logic [`DMEM_DWIDTH-1:0] shifted;
    logic [`DMEM_DWIDTH-1:0] ext;
    logic                    rsp_valid;
    logic                    rsp_fault;
    logic [`DMEM_DWIDTH-1:0] rsp_data;

    // addressed byte or halfword moved down to bit 0
    assign shifted = i_rdata >> {i_load_ctx.off, 3'b000};

    always_comb begin
        case (i_load_ctx.op)
            OP_LB:   ext = {{24{shifted[7]}}, shifted[7:0]};
            OP_LH:   ext = {{16{shifted[15]}}, shifted[15:0]};
            OP_LW:   ext = shifted;
            OP_LBU:  ext = {24'h0, shifted[7:0]};
            OP_LHU:  ext = {16'h0, shifted[15:0]};
            default: ext = '0;  // stores answer with zero
        endcase
        if (i_load_ctx.fault) begin
            ext = '0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rsp_valid <= 1'b0;
            rsp_fault <= 1'b0;
        end else begin
            rsp_valid <= i_load_ctx.valid;
            rsp_fault <= i_load_ctx.valid & i_load_ctx.fault;
        end
    end

    always_ff @(posedge i_clk) begin
        rsp_data <= ext;
    end

    always_comb begin
        o_rsp.valid = rsp_valid;
        o_rsp.fault = rsp_fault;
        o_rsp.data  = rsp_data;
    end

endmodule

`default_nettype wire

//--- hdl/ram_1rw.sv
`timescale 1ns/1ps
`default_nettype none

module ram_1rw #(
    parameter int DEPTH  = 64,
    parameter int DWIDTH = 32
) (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_cs_n,
    input  wire                    i_we_n,
    input  wire [DWIDTH/8-1:0]     i_wmask,
    input  wire [$clog2(DEPTH)-1:0] i_addr,
    input  wire [DWIDTH-1:0]       i_wdata,
    output logic [DWIDTH-1:0]      o_rdata
);

    localparam int NBYTES = DWIDTH / 8;

    logic [DWIDTH-1:0] rdata_q;

    assign o_rdata = rdata_q;

    // one narrow array per byte lane, each with its own write enable.
    // the read register samples before the write lands, so a same-cycle
    // read of the written word returns the old contents
    for (genvar b = 0; b < NBYTES; b++) begin : g_lane
        logic [7:0] mem [DEPTH];

        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                rdata_q[b*8 +: 8] <= 8'h00;
            end else if (!i_cs_n) begin
                if (!i_we_n && i_wmask[b]) begin
                    mem[i_addr] <= i_wdata[b*8 +: 8];
                end
                rdata_q[b*8 +: 8] <= mem[i_addr];  // old data
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/store_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmem_defines.svh"

module store_align
    import dmem_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_req,
    input  wire        mem_req_t i_req_bits,
    output ram_cmd_t   o_ram_cmd,
    output load_ctx_t  o_load_ctx
);

    mem_op_e                   op;
    logic [1:0]                off;
    logic                      is_store;
    logic                      is_half;
    logic                      is_word;
    logic                      misaligned;
    logic [`DMEM_DWIDTH/8-1:0] mask;
    logic [`DMEM_DWIDTH-1:0]   wdata;

    assign op  = i_req_bits.op;
    assign off = i_req_bits.addr[1:0];

    always_comb begin
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (op)
            OP_LH, OP_LHU: is_half = 1'b1;
            OP_LW:         is_word = 1'b1;
            OP_SB:         is_store = 1'b1;
            OP_SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            OP_SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: ;  // byte loads
        endcase
    end

    assign misaligned = (is_half & off[0]) | (is_word & (|off));

    // lane select, data replicated so the mask alone picks the lane
    always_comb begin
        if (is_word) begin
            mask  = 4'b1111;
            wdata = i_req_bits.data;
        end else if (is_half) begin
            mask  = off[1] ? 4'b1100 : 4'b0011;
            wdata = {2{i_req_bits.data[15:0]}};
        end else begin
            mask  = 4'b0001 << off;
            wdata = {4{i_req_bits.data[7:0]}};
        end
    end

    always_comb begin
        o_ram_cmd.cs_n  = ~(i_req & ~misaligned);  // faulting access never reaches the RAM
        o_ram_cmd.we_n  = ~is_store;
        o_ram_cmd.wmask = is_store ? mask : '0;
        o_ram_cmd.addr  = i_req_bits.addr[`DMEM_AWIDTH-1:2];
        o_ram_cmd.wdata = wdata;
    end

    // lines up with the RAM read register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_load_ctx <= '0;
        end else begin
            o_load_ctx.valid <= i_req;
            o_load_ctx.op    <= op;
            o_load_ctx.off   <= off;
            o_load_ctx.fault <= i_req & misaligned;
        end
    end

endmodule

`default_nettype wire

//--- testbench/dmem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_properties
    import dmem_pkg::*;
(
    input wire            i_clk,
    input wire            i_rst_n,
    input wire            i_req,
    input wire load_rsp_t o_rsp
);

    int fail_count = 0;

    a_rsp_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_req |-> ##2 o_rsp.valid)
    else begin
        fail_count++;
        $error("no response two cycles after a request");
    end

    // a response must trace back to a strobe two edges earlier
    a_no_spurious_rsp: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rsp.valid |-> $past(i_req, 2))
    else begin
        fail_count++;
        $error("response without a request");
    end

    a_fault_with_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rsp.fault |-> o_rsp.valid)
    else begin
        fail_count++;
        $error("fault flag set without valid");
    end

endmodule

bind dmem_top dmem_properties u_props (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_req   (i_req),
    .o_rsp   (o_rsp)
);

`default_nettype wire

//--- testbench/tb_dmem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmem_defines.svh"

module tb_dmem_top
    import dmem_pkg::*;
;

    typedef struct packed {
        logic                    req;
        mem_op_e                 op;
        logic [`DMEM_AWIDTH-1:0] addr;
        logic [`DMEM_DWIDTH-1:0] wdata;
        logic                    exp_fault;
        logic [`DMEM_DWIDTH-1:0] exp_data;
        logic [2:0]              grp;
    } entry_t;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_req;
    mem_req_t  i_req_bits;
    load_rsp_t o_rsp;

    entry_t     tbl[$];
    int         pending[$];           // table indices waiting for their response
    logic [7:0] ref_mem [1 << `DMEM_AWIDTH];
    int         seed = 15466;
    int         n_checks = 0;
    int         n_errors = 0;
    int         cur_grp = 0;
    int         grp_err[5] = '{0, 0, 0, 0, 0};
    string      grp_name[5] = '{"word store/load", "byte/half merge", "sign/zero extend",
                                "misaligned fault", "store response and idle"};
    bit         table_ready = 1'b0;

    dmem_top DUT (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (i_req),
        .i_req_bits (i_req_bits),
        .o_rsp      (o_rsp)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // stores update the byte reference and loads gather and extend its bytes
    task automatic add_entry(input logic req, input mem_op_e op, input int addr,
                             input logic [31:0] wdata, input int grp);
        entry_t      e;
        int          size;
        logic [31:0] val;
        e.req       = req;
        e.op        = op;
        e.addr      = addr[`DMEM_AWIDTH-1:0];
        e.wdata     = wdata;
        e.exp_fault = 1'b0;
        e.exp_data  = '0;
        e.grp       = grp[2:0];
        size = (op == OP_LB || op == OP_LBU || op == OP_SB) ? 1 :
               (op == OP_LH || op == OP_LHU || op == OP_SH) ? 2 : 4;
        if (req) begin
            if (addr % size != 0) begin
                e.exp_fault = 1'b1;
            end else if (op == OP_SB || op == OP_SH || op == OP_SW) begin
                for (int i = 0; i < size; i++)
                    ref_mem[addr + i] = wdata[8*i +: 8];
            end else begin
                val = '0;
                for (int i = 0; i < size; i++)
                    val[8*i +: 8] = ref_mem[addr + i];
                if ((op == OP_LB || op == OP_LH) && val[8*size-1])
                    val = val | (32'hffff_ffff << (8 * size));
                e.exp_data = val;
            end
        end
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // words 0..7 back to back, then read back after a gap
        for (int i = 0; i < 8; i++)
            add_entry(1, OP_SW, 4 * i, rand_word(), 0);
        add_entry(0, OP_LW, 0, 0, 0);
        for (int i = 0; i < 8; i++)
            add_entry(1, OP_LW, 4 * i, 0, 0);
        add_entry(1, OP_SB, 1, rand_word(), 1);
        add_entry(1, OP_SB, 6, rand_word(), 1);
        add_entry(1, OP_SH, 10, rand_word(), 1);
        add_entry(1, OP_SH, 12, rand_word(), 1);
        add_entry(1, OP_SB, 15, rand_word(), 1);
        add_entry(1, OP_LW, 12, 0, 1);                 // right after the store
        for (int i = 0; i < 3; i++)
            add_entry(1, OP_LW, 4 * i, 0, 1);
        add_entry(1, OP_SW, 32, 32'h8a7f_f480, 2);
        add_entry(1, OP_SW, 36, 32'h7fff_8001, 2);
        for (int w = 32; w <= 36; w += 4) begin
            for (int o = 0; o < 4; o++) begin
                add_entry(1, OP_LB, w + o, 0, 2);
                add_entry(1, OP_LBU, w + o, 0, 2);
            end
            for (int o = 0; o < 4; o += 2) begin
                add_entry(1, OP_LH, w + o, 0, 2);
                add_entry(1, OP_LHU, w + o, 0, 2);
            end
        end
        add_entry(1, OP_SW, 40, rand_word(), 3);
        add_entry(1, OP_LH, 33, 0, 3);
        add_entry(1, OP_LW, 34, 0, 3);
        add_entry(1, OP_LHU, 35, 0, 3);
        add_entry(1, OP_SH, 41, rand_word(), 3);
        add_entry(1, OP_SW, 42, rand_word(), 3);
        add_entry(1, OP_LW, 40, 0, 3);                 // must be untouched
        add_entry(1, OP_SB, 44, rand_word(), 4);
        add_entry(0, OP_SW, 44, rand_word(), 4);       // junk on the bus without a strobe
        add_entry(0, OP_LW, 44, 0, 4);
        add_entry(1, OP_SH, 46, rand_word(), 4);
        add_entry(1, OP_LBU, 44, 0, 4);
        add_entry(1, OP_LHU, 46, 0, 4);
        add_entry(0, OP_LB, 0, 0, 4);
        add_entry(0, OP_LB, 0, 0, 4);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            grp_err[cur_grp]++;
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic check_response(input int k);
        entry_t e;
        e = tbl[k];
        cur_grp = e.grp;
        if (e.req) begin
            check_value("o_rsp.valid", 32'd1, o_rsp.valid);
            check_value("o_rsp.fault", e.exp_fault, o_rsp.fault);
            check_value("o_rsp.data", e.exp_data, o_rsp.data);
        end else begin
            check_value("o_rsp.valid", 32'd0, o_rsp.valid);
        end
        if (k == tbl.size() - 1 || tbl[k + 1].grp != e.grp)
            $display("test %0d (%s): %0d errors", e.grp + 1, grp_name[e.grp], grp_err[e.grp]);
    endtask

    initial begin : watchdog
        wait (table_ready);
        #((tbl.size() + 20) * 4);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int total;
        i_rst_n    = 1'b0;
        i_req      = 1'b0;
        i_req_bits = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        cur_grp = 4;
        check_value("o_rsp.valid", 32'd0, o_rsp.valid);    // nothing out of reset
        check_value("o_rsp.fault", 32'd0, o_rsp.fault);
        for (int k = 0; k < tbl.size(); k++) begin
            @(negedge i_clk);
            if (pending.size() == 2)
                check_response(pending.pop_front());
            i_req           = tbl[k].req;
            i_req_bits.op   = tbl[k].op;
            i_req_bits.addr = tbl[k].addr;
            i_req_bits.data = tbl[k].wdata;
            pending.push_back(k);
        end
        while (pending.size() > 0) begin
            @(negedge i_clk);
            i_req = 1'b0;
            check_response(pending.pop_front());
        end
        total = n_errors + DUT.u_props.fail_count;
        $display("checks=%0d errors=%0d assertion_failures=%0d",
                 n_checks, n_errors, DUT.u_props.fail_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
